//--- Bender.yml
package:
  name: rv32i_id_stage

sources:
  # Decode stage RTL, package first
  - files:
      - source/id_pkg.sv
      - source/rv_decoder.sv
      - source/id_regfile.sv
      - source/operand_fwd.sv
      - source/operand_mux.sv
      - source/id_ex_pipe.sv
      - source/id_stage.sv

  # Testbench, top module tb_id_stage
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_id_stage.sv

//--- filelist.f
source/id_pkg.sv
source/rv_decoder.sv
source/id_regfile.sv
source/operand_fwd.sv
source/operand_mux.sv
source/id_ex_pipe.sv
source/id_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_id_stage.sv

//--- source/id_ex_pipe.sv
/* ID/EX pipeline register with the stage handshake. Loads on accept,
   holds while EX stalls and inserts a bubble when nothing is accepted. */

`timescale 1ns/1ps

module id_ex_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  id_pkg::if_id_t          if_id_i,
  input  logic                    kill_i,
  input  logic                    ex_ready_i,
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [id_pkg::XLEN-1:0] operand_a_i,
  input  logic [id_pkg::XLEN-1:0] operand_b_i,
  input  logic [id_pkg::XLEN-1:0] operand_c_i,
  output logic                    id_ready_o,
  output logic                    jmp_valid_o,
  output id_pkg::id_ex_t          id_ex_o
);

  import id_pkg::*;

  logic accept;

  // A killed instruction is dropped, so ID is free to take the next one
  assign id_ready_o  = kill_i || ex_ready_i;
  assign accept      = if_id_i.valid && id_ready_o && !kill_i;
  assign jmp_valid_o = accept && ((ctrl_i.xfer == XFER_JAL) || (ctrl_i.xfer == XFER_JALR));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (accept) begin
      id_ex_o.valid     <= 1'b1;
      id_ex_o.alu_op    <= ctrl_i.alu_op;
      id_ex_o.operand_a <= operand_a_i;
      id_ex_o.operand_b <= operand_b_i;
      id_ex_o.operand_c <= operand_c_i;
      id_ex_o.rf_we     <= ctrl_i.rf_we;
      id_ex_o.rf_waddr  <= if_id_i.instr[RD_LSB +: REG_ADDR_W];
      id_ex_o.lsu_en    <= ctrl_i.lsu_en;
      // LSU attributes only change for memory instructions
      if (ctrl_i.lsu_en) begin
        id_ex_o.lsu_we       <= ctrl_i.lsu_we;
        id_ex_o.lsu_size     <= ctrl_i.lsu_size;
        id_ex_o.lsu_sign_ext <= ctrl_i.lsu_sign_ext;
      end
      id_ex_o.branch  <= (ctrl_i.xfer == XFER_BRANCH);
      id_ex_o.pc      <= if_id_i.pc;
      id_ex_o.illegal <= ctrl_i.illegal;
    end else if (ex_ready_i) begin
      // EX took the old entry and nothing new came in
      id_ex_o.valid <= 1'b0;
    end
  end

endmodule

//--- source/id_pkg.sv
/* Shared widths, instruction field positions, opcodes, enums and structs
   for the RV32I decode stage. Every module of the stage imports this package. */

package id_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and instruction fields
  ////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // Low bit of each register index in the instruction word
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RD_LSB  = 7;

  // Link increment, no compressed instructions
  localparam logic [XLEN-1:0] PC_INCR = 'd4;

  ////////////////////////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  ////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////

  // Arithmetic ops first, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_REG, OP_B_IMM_I, OP_B_IMM_S, OP_B_IMM_U, OP_B_PCINCR
  } op_b_sel_e;

  typedef enum logic [1:0] {OP_C_RS2, OP_C_BCH, OP_C_ZERO} op_c_sel_e;

  typedef enum logic [1:0] {XFER_NONE, XFER_BRANCH, XFER_JAL, XFER_JALR} xfer_e;

  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

  ////////////////////////////////////////////////////////////
  // Structs
  ////////////////////////////////////////////////////////////

  // Fetch to decode
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  // One register write, EX forward port or WB write port
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } wr_port_t;

  // Decoder output
  typedef struct packed {
    alu_op_e   alu_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    xfer_e     xfer;
    logic [1:0] rf_re;
    logic      rf_we;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sign_ext;
    logic      illegal;
  } dec_ctrl_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  lsu_en;
    logic                  lsu_we;
    lsu_size_e             lsu_size;
    logic                  lsu_sign_ext;
    logic                  branch;
    logic [XLEN-1:0]       pc;
    logic                  illegal;
  } id_ex_t;

endpackage

//--- source/id_regfile.sv
/* Integer register file x1 to x31 with two asynchronous read ports and
   one write port from WB. x0 is not stored and always reads zero. */

`timescale 1ns/1ps

module id_regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [id_pkg::XLEN-1:0]       rdata_a_o,
  output logic [id_pkg::XLEN-1:0]       rdata_b_o,
  input  id_pkg::wr_port_t              wr_i
);

  import id_pkg::*;

  // Storage for x1 and up
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  // Write port, address 0 is dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.waddr != '0)) begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Read ports
  always_comb begin
    rdata_a_o = '0;
    rdata_b_o = '0;
    if (raddr_a_i != '0) begin
      rdata_a_o = regs[raddr_a_i];
    end
    if (raddr_b_i != '0) begin
      rdata_b_o = regs[raddr_b_i];
    end
  end

endmodule

//--- source/id_stage.sv
/* Top of the RV32I instruction decode stage. Connects decoder, register
   file, forwarding, operand muxes and the ID/EX register. */

`timescale 1ns/1ps

module id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  input  id_pkg::if_id_t          if_id_i,
  input  logic                    kill_i,
  input  id_pkg::wr_port_t        ex_fwd_i,
  input  id_pkg::wr_port_t        wb_wr_i,
  input  logic                    ex_ready_i,
  output logic                    id_ready_o,
  output id_pkg::id_ex_t          id_ex_o,
  output logic                    jmp_valid_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);

  import id_pkg::*;

  dec_ctrl_t             ctrl;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  logic [XLEN-1:0]       operand_a;
  logic [XLEN-1:0]       operand_b;
  logic [XLEN-1:0]       operand_c;

  // Source register fields
  assign rs1 = if_id_i.instr[RS1_LSB +: REG_ADDR_W];
  assign rs2 = if_id_i.instr[RS2_LSB +: REG_ADDR_W];

  rv_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl)
  );

  id_regfile u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wr_i      (wb_wr_i)
  );

  operand_fwd u_fwd (
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .ex_fwd_i     (ex_fwd_i),
    .wb_wr_i      (wb_wr_i),
    .rs1_val_o    (rs1_val),
    .rs2_val_o    (rs2_val)
  );

  operand_mux u_opmux (
    .instr_i      (if_id_i.instr),
    .pc_i         (if_id_i.pc),
    .ctrl_i       (ctrl),
    .rs1_val_i    (rs1_val),
    .rs2_val_i    (rs2_val),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b),
    .operand_c_o  (operand_c),
    .jmp_target_o (jmp_target_o)
  );

  id_ex_pipe u_pipe (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_id_i     (if_id_i),
    .kill_i      (kill_i),
    .ex_ready_i  (ex_ready_i),
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .id_ready_o  (id_ready_o),
    .jmp_valid_o (jmp_valid_o),
    .id_ex_o     (id_ex_o)
  );

endmodule

//--- source/operand_fwd.sv
/* Source operand forwarding. Each source takes the EX result first, then
   the WB write, and falls back to the register file read value. */

`timescale 1ns/1ps

module operand_fwd (
  input  logic [id_pkg::REG_ADDR_W-1:0] rs1_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] rs2_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [id_pkg::XLEN-1:0]       rf_rdata_b_i,
  input  id_pkg::wr_port_t              ex_fwd_i,
  input  id_pkg::wr_port_t              wb_wr_i,
  output logic [id_pkg::XLEN-1:0]       rs1_val_o,
  output logic [id_pkg::XLEN-1:0]       rs2_val_o
);

  import id_pkg::*;

  // A write matches only with we set and the same nonzero index
  function automatic logic wr_hit(input logic [REG_ADDR_W-1:0] rs, input wr_port_t wr);
    return wr.we && (rs != '0) && (wr.waddr == rs);
  endfunction

  // Priority pick for one source register
  function automatic logic [XLEN-1:0] fwd_value(
    input logic [REG_ADDR_W-1:0] rs,
    input logic [XLEN-1:0]       rf_val,
    input wr_port_t              ex,
    input wr_port_t              wb
  );
    logic [XLEN-1:0] val;
    if (wr_hit(rs, ex)) begin
      val = ex.wdata;
    end else if (wr_hit(rs, wb)) begin
      val = wb.wdata;
    end else begin
      // x0 arrives as zero from the register file
      val = rf_val;
    end
    return val;
  endfunction

  assign rs1_val_o = fwd_value(rs1_i, rf_rdata_a_i, ex_fwd_i, wb_wr_i);
  assign rs2_val_o = fwd_value(rs2_i, rf_rdata_b_i, ex_fwd_i, wb_wr_i);

endmodule

//--- source/operand_mux.sv
/* Immediate extraction and operand selection for the ID stage. Builds
   operands A, B and C, the branch target and the JAL/JALR jump target. */

`timescale 1ns/1ps

module operand_mux (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  input  logic [id_pkg::XLEN-1:0] pc_i,
  input  id_pkg::dec_ctrl_t       ctrl_i,
  input  logic [id_pkg::XLEN-1:0] rs1_val_i,
  input  logic [id_pkg::XLEN-1:0] rs2_val_i,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o,
  output logic [id_pkg::XLEN-1:0] operand_c_o,
  output logic [id_pkg::XLEN-1:0] jmp_target_o
);

  import id_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] bch_target;

  ////////////////////////////////////////////////////////////
  // Immediates, all sign extended from bit 31
  ////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // Sources not read by the instruction show up as zero
  assign rs1_val = ctrl_i.rf_re[0] ? rs1_val_i : '0;
  assign rs2_val = ctrl_i.rf_re[1] ? rs2_val_i : '0;

  ////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////

  assign bch_target = pc_i + imm_b;

  // JALR clears bit 0 of the sum
  always_comb begin
    if (ctrl_i.xfer == XFER_JALR) begin
      jmp_target_o = (rs1_val + imm_i) & ~XLEN'(1);
    end else begin
      jmp_target_o = pc_i + imm_j;
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_val;
    endcase

    case (ctrl_i.op_b_sel)
      OP_B_IMM_I:  operand_b_o = imm_i;
      OP_B_IMM_S:  operand_b_o = imm_s;
      OP_B_IMM_U:  operand_b_o = imm_u;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_val;
    endcase

    // Store data or branch target
    case (ctrl_i.op_c_sel)
      OP_C_RS2: operand_c_o = rs2_val;
      OP_C_BCH: operand_c_o = bch_target;
      default:  operand_c_o = '0;
    endcase
  end

endmodule

//--- source/rv_decoder.sv
/* RV32I decoder for the ID stage. Maps opcode, funct3 and funct7 to the
   control struct and flags every encoding outside the supported subset. */

`timescale 1ns/1ps

module rv_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_i,
  output id_pkg::dec_ctrl_t       ctrl_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // ALU op of the register and immediate groups, alt picks SUB and SRA
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  ////////////////////////////////////////////////////////////
  // Decode table
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults describe a harmless ADD with nothing enabled
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.op_a_sel = OP_A_REG;
    ctrl_o.op_b_sel = OP_B_REG;
    ctrl_o.op_c_sel = OP_C_ZERO;
    ctrl_o.xfer     = XFER_NONE;
    ctrl_o.lsu_size = LSU_WORD;

    case (opcode)
      OPC_OP: begin
        ctrl_o.rf_re  = 2'b11;
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = alu_from_funct3(funct3, funct7[5]);
        // Only SUB and SRA use the alternate funct7
        if (funct7 == 7'b0100000) begin
          ctrl_o.illegal = !((funct3 == 3'b000) || (funct3 == 3'b101));
        end else if (funct7 != 7'b0000000) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        ctrl_o.rf_re    = 2'b01;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM_I;
        ctrl_o.alu_op   = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // Shift amounts carry a funct7 that must be checked
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OPC_LUI: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM_U;
      end
      OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM_U;
      end
      OPC_LOAD: begin
        ctrl_o.rf_re        = 2'b01;
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.op_b_sel     = OP_B_IMM_I;
        ctrl_o.lsu_en       = 1'b1;
        ctrl_o.lsu_size     = lsu_size_e'(funct3[1:0]);
        ctrl_o.lsu_sign_ext = !funct3[2];
        // LB LH LW LBU LHU
        ctrl_o.illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end
      OPC_STORE: begin
        ctrl_o.rf_re    = 2'b11;
        ctrl_o.op_b_sel = OP_B_IMM_S;
        ctrl_o.op_c_sel = OP_C_RS2;
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
        ctrl_o.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_BRANCH: begin
        ctrl_o.rf_re    = 2'b11;
        ctrl_o.op_c_sel = OP_C_BCH;
        ctrl_o.xfer     = XFER_BRANCH;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      // Jumps compute the link address pc + 4 in the ALU
      OPC_JAL: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.xfer     = XFER_JAL;
      end
      OPC_JALR: begin
        ctrl_o.rf_re    = 2'b01;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.xfer     = XFER_JALR;
        ctrl_o.illegal  = (funct3 != 3'b000);
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words travel down the pipe without side effects
    // Both sources are read speculatively
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we  = 1'b0;
      ctrl_o.lsu_en = 1'b0;
      ctrl_o.rf_re  = 2'b11;
      ctrl_o.xfer   = XFER_NONE;
    end
  end

endmodule

//--- testbench/tb_clk_gen.sv
/* Testbench clock and reset source. 40 ns clock period, active low reset
   held for the first two rising edges. */

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam time HALF_PERIOD = 20ns;
  localparam int  RESET_CYCLES = 2;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // Release on the edge like every other stimulus
    rst_n <= 1'b1;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- testbench/tb_id_stage.sv
/* Random testbench for the decode stage. A model with a shadow register file
   predicts every ID/EX entry and jump, and the run ends with a pass/fail line. */

`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  localparam int N_PER_TEST  = 200;
  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = 4 * N_PER_TEST * NUM_TESTS + 100;

  logic clk;
  logic rst_n;
  if_id_t if_id_i;
  logic kill_i;
  wr_port_t ex_fwd_i;
  wr_port_t wb_wr_i;
  logic ex_ready_i;
  logic id_ready_o;
  id_ex_t id_ex_o;
  logic jmp_valid_o;
  logic [XLEN-1:0] jmp_target_o;

  integer seed = 16;
  int reg_span = 8;
  int ready_pct = 75;
  int kill_pct = 5;
  int err_count = 0;
  int pass_cnt = 0;
  int fail_cnt = 0;
  int cycle_count = 0;
  logic [XLEN-1:0] shadow [NUM_REGS];
  id_ex_t exp_q [$];
  id_ex_t held;
  id_ex_t exp_entry;
  logic was_accepted = 1'b0;
  logic was_stalled = 1'b0;
  logic exp_ready;
  logic exp_jv;
  logic [XLEN-1:0] exp_jt;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  id_stage uut (
    .clk (clk), .rst_n (rst_n), .if_id_i (if_id_i), .kill_i (kill_i),
    .ex_fwd_i (ex_fwd_i), .wb_wr_i (wb_wr_i), .ex_ready_i (ex_ready_i),
    .id_ready_o (id_ready_o), .id_ex_o (id_ex_o), .jmp_valid_o (jmp_valid_o),
    .jmp_target_o (jmp_target_o)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return {$random(seed)} % n;
  endfunction

  // EX beats WB beats the shadow copy and x0 is pinned to zero
  function automatic logic [XLEN-1:0] src_value(input logic [4:0] idx, input wr_port_t ex,
                                                input wr_port_t wb);
    logic [XLEN-1:0] v;
    v = shadow[idx];
    if (wb.we && (wb.waddr == idx)) v = wb.wdata;
    if (ex.we && (ex.waddr == idx)) v = ex.wdata;
    if (idx == 5'd0) v = '0;
    return v;
  endfunction

  function automatic alu_op_e expected_alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? ALU_SUB : ALU_ADD;
      3'd1: return ALU_SLL;
      3'd2: return ALU_SLT;
      3'd3: return ALU_SLTU;
      3'd4: return ALU_XOR;
      3'd5: return alt ? ALU_SRA : ALU_SRL;
      3'd6: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // BEQ BNE then the signed and unsigned compares
  function automatic alu_op_e expected_cmp_op(input logic [2:0] f3);
    case (f3)
      3'd0: return ALU_EQ;
      3'd1: return ALU_NE;
      3'd4: return ALU_LT;
      3'd5: return ALU_GE;
      3'd6: return ALU_LTU;
      default: return ALU_GEU;
    endcase
  endfunction

  function automatic id_ex_t model_decode(input if_id_t f, input wr_port_t ex,
                                          input wr_port_t wb, output logic jv,
                                          output logic [XLEN-1:0] jt);
    id_ex_t e;
    logic [XLEN-1:0] ins, rs1, rs2;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0] f3;
    ins = f.instr;
    f3 = ins[14:12];
    rs1 = src_value(ins[19:15], ex, wb);
    rs2 = src_value(ins[24:20], ex, wb);
    // Immediates built on top of the I-type sign bits
    imm_i = $signed(ins) >>> 20;
    imm_s = {imm_i[31:5], ins[11:7]};
    imm_b = {imm_s[31:12], ins[7], imm_s[10:1], 1'b0};
    imm_u = {ins[31:12], 12'h000};
    imm_j = {imm_i[31:20], ins[19:12], ins[20], ins[30:21], 1'b0};
    e = '0;
    e.valid = 1'b1;
    e.pc = f.pc;
    e.rf_waddr = ins[11:7];
    e.alu_op = ALU_ADD;
    jv = 1'b0;
    jt = '0;
    case (ins[6:0])
      OPC_OP: begin
        e.alu_op = expected_alu_op(f3, ins[30]);
        e.operand_a = rs1;
        e.operand_b = rs2;
        e.rf_we = 1'b1;
      end
      OPC_OP_IMM: begin
        e.alu_op = expected_alu_op(f3, (f3 == 3'd5) && ins[30]);
        e.operand_a = rs1;
        e.operand_b = imm_i;
        e.rf_we = 1'b1;
      end
      OPC_LUI, OPC_AUIPC: begin
        e.operand_a = (ins[6:0] == OPC_AUIPC) ? f.pc : '0;
        e.operand_b = imm_u;
        e.rf_we = 1'b1;
      end
      OPC_LOAD, OPC_STORE: begin
        e.operand_a = rs1;
        e.lsu_en = 1'b1;
        e.lsu_size = lsu_size_e'(f3[1:0]);
        e.lsu_we = (ins[6:0] == OPC_STORE);
        e.rf_we = !e.lsu_we;
        e.lsu_sign_ext = !e.lsu_we && !f3[2];
        e.operand_b = e.lsu_we ? imm_s : imm_i;
        e.operand_c = e.lsu_we ? rs2 : '0;
      end
      OPC_BRANCH: begin
        e.alu_op = expected_cmp_op(f3);
        e.operand_a = rs1;
        e.operand_b = rs2;
        e.operand_c = f.pc + imm_b;
        e.branch = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value pc + 4 goes through the ALU
        e.operand_a = f.pc;
        e.operand_b = 32'd4;
        e.rf_we = 1'b1;
        jv = 1'b1;
        jt = (ins[6:0] == OPC_JAL) ? f.pc + imm_j : (rs1 + imm_i) & 32'hffff_fffe;
      end
      default: begin
        e.operand_a = rs1;
        e.operand_b = rs2;
        e.illegal = 1'b1;
      end
    endcase
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
    $display("Mismatch %s: expected 0x%08h, got 0x%08h at %0t", name, exp, act, $time);
    err_count++;
  endtask

  task automatic check_id_ex(input id_ex_t exp);
    id_ex_t act;
    act = id_ex_o;
    if (act.valid !== exp.valid) report_mismatch("id_ex_o.valid", exp.valid, act.valid);
    if (act.alu_op !== exp.alu_op) report_mismatch("id_ex_o.alu_op", exp.alu_op, act.alu_op);
    if (act.operand_a !== exp.operand_a) report_mismatch("id_ex_o.operand_a", exp.operand_a,
                                                         act.operand_a);
    if (act.operand_b !== exp.operand_b) report_mismatch("id_ex_o.operand_b", exp.operand_b,
                                                         act.operand_b);
    if (act.operand_c !== exp.operand_c) report_mismatch("id_ex_o.operand_c", exp.operand_c,
                                                         act.operand_c);
    if (act.rf_we !== exp.rf_we) report_mismatch("id_ex_o.rf_we", exp.rf_we, act.rf_we);
    if (act.rf_waddr !== exp.rf_waddr) report_mismatch("id_ex_o.rf_waddr", exp.rf_waddr,
                                                       act.rf_waddr);
    if (act.lsu_en !== exp.lsu_en) report_mismatch("id_ex_o.lsu_en", exp.lsu_en, act.lsu_en);
    // LSU attributes are kept stale outside memory ops
    if (exp.lsu_en) begin
      if (act.lsu_we !== exp.lsu_we) report_mismatch("id_ex_o.lsu_we", exp.lsu_we, act.lsu_we);
      if (act.lsu_size !== exp.lsu_size) report_mismatch("id_ex_o.lsu_size", exp.lsu_size,
                                                         act.lsu_size);
      if (act.lsu_sign_ext !== exp.lsu_sign_ext) report_mismatch("id_ex_o.lsu_sign_ext",
                                                                 exp.lsu_sign_ext,
                                                                 act.lsu_sign_ext);
    end
    if (act.branch !== exp.branch) report_mismatch("id_ex_o.branch", exp.branch, act.branch);
    if (act.pc !== exp.pc) report_mismatch("id_ex_o.pc", exp.pc, act.pc);
    if (act.illegal !== exp.illegal) report_mismatch("id_ex_o.illegal", exp.illegal,
                                                     act.illegal);
  endtask

  task automatic check_target(input logic [XLEN-1:0] exp);
    if (jmp_target_o !== exp) report_mismatch("jmp_target_o", exp, jmp_target_o);
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor that runs at the falling edge where everything is settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      // What the last rising edge should have left in the register
      if (was_stalled) begin
        check_id_ex(held);
      end else if (was_accepted) begin
        if (exp_q.size() == 0) begin
          $display("Error: an accepted instruction has no expected entry at %0t", $time);
          err_count++;
        end else begin
          check_id_ex(exp_q.pop_front());
        end
      end else begin
        check_flag("id_ex_o.valid", 1'b0, id_ex_o.valid);
      end
      // Handshake of the current cycle
      exp_ready = kill_i || ex_ready_i;
      check_flag("id_ready_o", exp_ready, id_ready_o);
      was_accepted = if_id_i.valid && exp_ready && !kill_i;
      was_stalled = !ex_ready_i;
      held = id_ex_o;
      exp_jv = 1'b0;
      if (was_accepted) begin
        exp_entry = model_decode(if_id_i, ex_fwd_i, wb_wr_i, exp_jv, exp_jt);
        exp_q.push_back(exp_entry);
        if (exp_jv) check_target(exp_jt);
      end
      check_flag("jmp_valid_o", exp_jv, jmp_valid_o);
      // WB lands in the register file at the coming edge
      if (wb_wr_i.we && (wb_wr_i.waddr != '0)) shadow[wb_wr_i.waddr] = wb_wr_i.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Class 0 ALU, 1 LUI/AUIPC, 2 load/store, 3 branch, 4 jump, 5 illegal
  function automatic logic [XLEN-1:0] gen_instr(input logic [5:0] mask);
    int cls;
    int idx;
    logic pick, alt;
    logic [XLEN-1:0] w;
    logic [2:0] f3;
    cls = rand_below(6);
    while (!mask[cls]) cls = rand_below(6);
    pick = rand_below(2) == 1;
    alt = rand_below(2) == 1;
    w = $random(seed);
    w[19:15] = 5'(rand_below(reg_span));
    w[11:7] = 5'(rand_below(reg_span));
    f3 = w[14:12];
    case (cls)
      0: begin
        if (pick) begin
          w[6:0] = OPC_OP;
          w[24:20] = 5'(rand_below(reg_span));
          w[31:25] = (alt && ((f3 == 3'd0) || (f3 == 3'd5))) ? 7'h20 : 7'h00;
        end else begin
          w[6:0] = OPC_OP_IMM;
          if (f3 == 3'd1) w[31:25] = 7'h00;
          if (f3 == 3'd5) w[31:25] = alt ? 7'h20 : 7'h00;
        end
      end
      1: w[6:0] = pick ? OPC_LUI : OPC_AUIPC;
      2: begin
        if (pick) begin
          w[6:0] = OPC_LOAD;
          idx = rand_below(5);
          f3 = 3'(idx < 3 ? idx : idx + 1);
        end else begin
          w[6:0] = OPC_STORE;
          w[24:20] = 5'(rand_below(reg_span));
          f3 = 3'(rand_below(3));
        end
      end
      3: begin
        w[6:0] = OPC_BRANCH;
        w[24:20] = 5'(rand_below(reg_span));
        idx = rand_below(6);
        f3 = 3'(idx < 2 ? idx : idx + 2);
      end
      4: begin
        w[6:0] = pick ? OPC_JAL : OPC_JALR;
        if (!pick) f3 = 3'd0;
      end
      // Low opcode bits other than 11 are never a 32-bit instruction
      default: w[1:0] = 2'(rand_below(3));
    endcase
    w[14:12] = f3;
    return w;
  endfunction

  task automatic drive_side();
    ex_fwd_i.we <= rand_below(4) != 0;
    ex_fwd_i.waddr <= 5'(rand_below(reg_span));
    ex_fwd_i.wdata <= $random(seed);
    wb_wr_i.we <= rand_below(4) != 0;
    wb_wr_i.waddr <= 5'(rand_below(reg_span));
    wb_wr_i.wdata <= $random(seed);
    ex_ready_i <= rand_below(100) < ready_pct;
    kill_i <= rand_below(100) < kill_pct;
  endtask

  task automatic issue(input logic [XLEN-1:0] instr);
    logic taken;
    logic [XLEN-1:0] pc;
    taken = 1'b0;
    pc = $random(seed) & 32'hffff_fffc;
    if (rand_below(8) == 0) begin
      @(posedge clk);
      if_id_i.valid <= 1'b0;
      drive_side();
    end
    while (!taken) begin
      @(posedge clk);
      if_id_i <= {1'b1, pc, instr};
      drive_side();
      @(negedge clk);
      // Either accepted or dropped by kill
      taken = id_ready_o;
    end
  endtask

  task automatic run_test(input string name, input logic [5:0] mask, input int rdy,
                          input int kil, input int span);
    int err_before;
    err_before = err_count;
    ready_pct = rdy;
    kill_pct = kil;
    reg_span = span;
    repeat (N_PER_TEST) issue(gen_instr(mask));
    // Drain the last entry and let the monitor check it
    @(posedge clk);
    if_id_i.valid <= 1'b0;
    ex_ready_i <= 1'b1;
    kill_i <= 1'b0;
    ex_fwd_i.we <= 1'b0;
    wb_wr_i.we <= 1'b0;
    @(negedge clk);
    @(posedge clk);
    if (err_count == err_before) pass_cnt++;
    else fail_cnt++;
    $display("Test %s: %0d instructions, %0d errors", name, N_PER_TEST,
             err_count - err_before);
  endtask

  initial begin
    if_id_i = '0;
    kill_i = 1'b0;
    ex_fwd_i = '0;
    wb_wr_i = '0;
    ex_ready_i = 1'b1;
    for (int i = 0; i < NUM_REGS; i++) shadow[i] = '0;
    @(posedge rst_n);
    run_test("alu_lui_auipc", 6'b000011, 75, 5, 8);
    run_test("load_store", 6'b000100, 75, 5, 8);
    run_test("branch_jump", 6'b011000, 75, 5, 8);
    run_test("forwarding", 6'b011111, 75, 5, 4);
    run_test("backpressure_kill", 6'b111111, 50, 20, 8);
    run_test("illegal", 6'b100001, 75, 5, 8);
    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (err_count == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog against a stage that never takes an instruction
  initial begin
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
